// File: verilog/isa_pkg.sv
package isa_pkg;

    // ----------------------------------------------------------
    // architectural widths
    // ----------------------------------------------------------
    // integer data path width
    localparam int unsigned XLEN          = 64;
    // register index width and register count
    localparam int unsigned REG_ADDR_BITS = 5;
    localparam int unsigned NR_REGS       = 2 ** REG_ADDR_BITS;

    // unit that executes an instruction, also the owner of a pending write
    typedef enum logic [2:0] {
        FU_NONE,
        FU_ALU,
        FU_BRANCH,
        FU_LOAD,
        FU_STORE,
        FU_MULT,
        FU_CSR
    } fu_e;

    // integer subset of operations seen by issue
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_SLL,
        OP_LD,
        OP_SD,
        OP_BEQ,
        OP_JAL,
        OP_MUL,
        OP_CSRRW,
        OP_SFENCE_VMA
    } op_e;

    // sfence.vma may take a csr-owned operand from the scoreboard
    function automatic logic can_forward_csr(input op_e op);
        return op == OP_SFENCE_VMA;
    endfunction

endpackage

// File: verilog/issue_pkg.sv
package issue_pkg;

    import isa_pkg::*;

    // ----------------------------------------------------------
    // stage parameters
    // ----------------------------------------------------------
    // commit write ports into the regfile, 1 to 4 supported
    localparam int unsigned NR_COMMIT_PORTS = 2;
    // scoreboard tag width
    localparam int unsigned TRANS_ID_BITS   = 3;
    // virtual address width of the pc, sign extended to XLEN
    localparam int unsigned VLEN            = 39;

    // decoded instruction from the scoreboard
    typedef struct packed {
        logic [VLEN-1:0]          pc;
        logic [REG_ADDR_BITS-1:0] rs1;
        logic [REG_ADDR_BITS-1:0] rs2;
        logic [REG_ADDR_BITS-1:0] rd;
        logic [XLEN-1:0]          imm;
        fu_e                      fu;
        op_e                      op;
        logic [TRANS_ID_BITS-1:0] trans_id;
        // operand a from pc
        logic                     use_pc;
        // operand b from imm
        logic                     use_imm;
        // operand a from rs1 index, zero extended
        logic                     use_zimm;
    } issue_instr_t;

    // one regfile write from commit
    typedef struct packed {
        logic                     we;
        logic [REG_ADDR_BITS-1:0] waddr;
        logic [XLEN-1:0]          wdata;
    } commit_port_t;

    // scoreboard answer for one source register
    typedef struct packed {
        logic [XLEN-1:0] value;
        logic            valid;
    } sb_operand_t;

    // registered bundle handed to execute
    typedef struct packed {
        logic [XLEN-1:0]          operand_a;
        logic [XLEN-1:0]          operand_b;
        logic [XLEN-1:0]          imm;
        fu_e                      fu;
        op_e                      op;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } fu_data_t;

    // one valid pulse per execute unit
    typedef struct packed {
        logic alu;
        logic branch;
        logic lsu;
        logic mult;
        logic csr;
    } fu_valid_t;

    // pending writer of every integer register
    typedef fu_e [NR_REGS-1:0] clobber_vec_t;

endpackage

// File: verilog/int_regfile.sv
`timescale 1ns/1ps

module int_regfile import isa_pkg::*, issue_pkg::*; (
    input  logic                                   clk_i,
    input  logic                                   rst_uarch_ni,
    // read ports, combinational
    input  logic [REG_ADDR_BITS-1:0]               raddr_a_i,
    input  logic [REG_ADDR_BITS-1:0]               raddr_b_i,
    output logic [XLEN-1:0]                        rdata_a_o,
    output logic [XLEN-1:0]                        rdata_b_o,
    // write ports from commit
    input  commit_port_t [NR_COMMIT_PORTS-1:0]     commit_i
);

    // read view of all registers
    logic [XLEN-1:0] rf [NR_REGS];

    // x0 is a constant, never stored
    assign rf[0] = '0;

    // ----------------------------------------------------------
    // one flop row per register
    // ----------------------------------------------------------
    for (genvar r = 1; r < NR_REGS; r++) begin : gen_reg
        logic            wr_en;
        logic [XLEN-1:0] wr_data;
        logic [XLEN-1:0] reg_q;

        // scan ports in order so the highest matching port wins
        always_comb begin : wr_select
            wr_en   = 1'b0;
            wr_data = reg_q;
            for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
                if (commit_i[p].we && (commit_i[p].waddr == REG_ADDR_BITS'(r))) begin
                    wr_en   = 1'b1;
                    wr_data = commit_i[p].wdata;
                end
            end
        end

        always_ff @(posedge clk_i or negedge rst_uarch_ni) begin
            if (!rst_uarch_ni) begin
                reg_q <= '0;
            end else if (wr_en) begin
                reg_q <= wr_data;
            end
        end

        assign rf[r] = reg_q;
    end

    // written value is visible one cycle after the commit
    assign rdata_a_o = rf[raddr_a_i];
    assign rdata_b_o = rf[raddr_b_i];

endmodule

// File: verilog/operand_hazard.sv
`timescale 1ns/1ps

module operand_hazard import isa_pkg::*, issue_pkg::*; (
    input  issue_instr_t                           issue_instr_i,
    input  logic                                   issue_valid_i,
    // pending writers and scoreboard availability
    input  clobber_vec_t                           clobber_i,
    input  logic                                   sb_rs1_valid_i,
    input  logic                                   sb_rs2_valid_i,
    // commit writes of this cycle
    input  commit_port_t [NR_COMMIT_PORTS-1:0]     commit_i,
    // unit readiness
    input  logic                                   flu_ready_i,
    input  logic                                   lsu_ready_i,
    // a multiply was issued last cycle
    input  logic                                   mult_pending_i,
    output logic                                   fwd_rs1_o,
    output logic                                   fwd_rs2_o,
    output logic                                   issue_ack_o
);

    logic stall;
    logic fu_busy;
    logic rd_free;
    logic rd_committing;
    fu_e  rs1_owner;
    fu_e  rs2_owner;

    assign rs1_owner = clobber_i[issue_instr_i.rs1];
    assign rs2_owner = clobber_i[issue_instr_i.rs2];

    // ----------------------------------------------------------
    // source availability
    // ----------------------------------------------------------
    always_comb begin : src_check
        fwd_rs1_o = 1'b0;
        fwd_rs2_o = 1'b0;
        stall     = 1'b0;
        // zimm carries an immediate in rs1, nothing to wait for
        if (!issue_instr_i.use_zimm && (rs1_owner != FU_NONE)) begin
            // csr results only reach us through the regfile
            if (sb_rs1_valid_i &&
                ((rs1_owner != FU_CSR) || can_forward_csr(issue_instr_i.op))) begin
                fwd_rs1_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
        if (rs2_owner != FU_NONE) begin
            if (sb_rs2_valid_i &&
                ((rs2_owner != FU_CSR) || can_forward_csr(issue_instr_i.op))) begin
                fwd_rs2_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
    end

    // busy flag of the unit this instruction needs
    always_comb begin : unit_busy
        case (issue_instr_i.fu)
            FU_ALU, FU_BRANCH, FU_MULT, FU_CSR: fu_busy = ~flu_ready_i;
            FU_LOAD, FU_STORE:                  fu_busy = ~lsu_ready_i;
            default:                            fu_busy = 1'b0;
        endcase
    end

    // ----------------------------------------------------------
    // write-after-write check
    // ----------------------------------------------------------
    assign rd_free = (clobber_i[issue_instr_i.rd] == FU_NONE);

    // the pending writer retires this cycle, so rd frees up
    always_comb begin : rd_commit_check
        rd_committing = 1'b0;
        for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
            if (commit_i[p].we && (commit_i[p].waddr == issue_instr_i.rd)) begin
                rd_committing = 1'b1;
            end
        end
    end

    always_comb begin : issue_accept
        issue_ack_o = 1'b0;
        if (issue_valid_i) begin
            if (!stall && !fu_busy && (rd_free || rd_committing)) begin
                issue_ack_o = 1'b1;
            end
            // no unit involved, retire straight away
            if (issue_instr_i.fu == FU_NONE) begin
                issue_ack_o = 1'b1;
            end
        end
        // mult result bus is shared, only mult may follow mult
        if (mult_pending_i && (issue_instr_i.fu != FU_MULT)) begin
            issue_ack_o = 1'b0;
        end
    end

endmodule

// File: verilog/operand_mux.sv
`timescale 1ns/1ps

module operand_mux import isa_pkg::*, issue_pkg::*; (
    input  issue_instr_t    issue_instr_i,
    // regfile read data
    input  logic [XLEN-1:0] rdata_a_i,
    input  logic [XLEN-1:0] rdata_b_i,
    // scoreboard values
    input  logic [XLEN-1:0] sb_rs1_value_i,
    input  logic [XLEN-1:0] sb_rs2_value_i,
    input  logic            fwd_rs1_i,
    input  logic            fwd_rs2_i,
    output fu_data_t        fu_data_next_o
);

    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;

    // ----------------------------------------------------------
    // operand select, later rules override earlier ones
    // ----------------------------------------------------------
    always_comb begin : operand_select
        operand_a = fwd_rs1_i ? sb_rs1_value_i : rdata_a_i;
        operand_b = fwd_rs2_i ? sb_rs2_value_i : rdata_b_i;
        // auipc, jal style
        if (issue_instr_i.use_pc) begin
            operand_a = {{(XLEN-VLEN){issue_instr_i.pc[VLEN-1]}}, issue_instr_i.pc};
        end
        // csr immediate forms, zero extended
        if (issue_instr_i.use_zimm) begin
            operand_a = {{(XLEN-REG_ADDR_BITS){1'b0}}, issue_instr_i.rs1};
        end
        // stores and branches keep rs2, imm travels on its own field
        if (issue_instr_i.use_imm &&
            (issue_instr_i.fu != FU_STORE) && (issue_instr_i.fu != FU_BRANCH)) begin
            operand_b = issue_instr_i.imm;
        end
    end

    assign fu_data_next_o.operand_a = operand_a;
    assign fu_data_next_o.operand_b = operand_b;
    assign fu_data_next_o.imm       = issue_instr_i.imm;
    assign fu_data_next_o.fu        = issue_instr_i.fu;
    assign fu_data_next_o.op        = issue_instr_i.op;
    assign fu_data_next_o.trans_id  = issue_instr_i.trans_id;

endmodule

// File: verilog/dispatch_reg.sv
`timescale 1ns/1ps

module dispatch_reg import isa_pkg::*, issue_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_uarch_ni,
    input  logic      flush_i,
    // next bundle and handshake of this cycle
    input  fu_data_t  fu_data_next_i,
    input  logic      issue_valid_i,
    input  logic      issue_ack_i,
    // to execute, one cycle after acceptance
    output fu_data_t  fu_data_o,
    output fu_valid_t fu_valid_o,
    output logic      mult_pending_o
);

    fu_data_t  data_q;
    fu_valid_t valid_d;
    fu_valid_t valid_q;

    // ----------------------------------------------------------
    // unit valid decode
    // ----------------------------------------------------------
    always_comb begin : valid_next
        valid_d = '0;
        if (issue_valid_i && issue_ack_i) begin
            case (fu_data_next_i.fu)
                FU_ALU:             valid_d.alu    = 1'b1;
                FU_BRANCH:          valid_d.branch = 1'b1;
                // loads and stores share the lsu
                FU_LOAD, FU_STORE:  valid_d.lsu    = 1'b1;
                FU_MULT:            valid_d.mult   = 1'b1;
                FU_CSR:             valid_d.csr    = 1'b1;
                default:            valid_d        = '0;
            endcase
        end
        // a flushed instruction must not start its unit
        if (flush_i) begin
            valid_d = '0;
        end
    end

    // ----------------------------------------------------------
    // id to ex register
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_uarch_ni) begin
        if (!rst_uarch_ni) begin
            data_q.operand_a <= '0;
            data_q.operand_b <= '0;
            data_q.imm       <= '0;
            data_q.fu        <= FU_NONE;
            data_q.op        <= OP_ADD;
            data_q.trans_id  <= '0;
            valid_q          <= '0;
        end else begin
            // loads every cycle, qualified by the pulses
            data_q  <= fu_data_next_i;
            valid_q <= valid_d;
        end
    end

    assign fu_data_o      = data_q;
    assign fu_valid_o     = valid_q;
    // mult in flight this cycle blocks non-mult issue
    assign mult_pending_o = valid_q.mult;

endmodule

// File: verilog/issue_read_operands.sv
`timescale 1ns/1ps

module issue_read_operands import isa_pkg::*, issue_pkg::*; (
    input  logic                                   clk_i,
    input  logic                                   rst_uarch_ni,
    input  logic                                   flush_i,
    // from the scoreboard
    input  issue_instr_t                           issue_instr_i,
    input  logic                                   issue_valid_i,
    output logic                                   issue_ack_o,
    // scoreboard lookup of the sources
    output logic [REG_ADDR_BITS-1:0]               rs1_o,
    output logic [REG_ADDR_BITS-1:0]               rs2_o,
    input  sb_operand_t                            sb_rs1_i,
    input  sb_operand_t                            sb_rs2_i,
    input  clobber_vec_t                           clobber_i,
    // commit writes
    input  commit_port_t [NR_COMMIT_PORTS-1:0]     commit_i,
    // execute side
    input  logic                                   flu_ready_i,
    input  logic                                   lsu_ready_i,
    output fu_data_t                               fu_data_o,
    output fu_valid_t                              fu_valid_o
);

    logic            fwd_rs1;
    logic            fwd_rs2;
    logic            issue_ack;
    logic            mult_pending;
    logic [XLEN-1:0] rdata_a;
    logic [XLEN-1:0] rdata_b;
    fu_data_t        fu_data_next;

    assign rs1_o       = issue_instr_i.rs1;
    assign rs2_o       = issue_instr_i.rs2;
    assign issue_ack_o = issue_ack;

    // ----------------------------------------------------------
    // hazard check and acknowledge
    // ----------------------------------------------------------
    operand_hazard operand_hazard_i (
        .issue_instr_i  ( issue_instr_i  ),
        .issue_valid_i  ( issue_valid_i  ),
        .clobber_i      ( clobber_i      ),
        .sb_rs1_valid_i ( sb_rs1_i.valid ),
        .sb_rs2_valid_i ( sb_rs2_i.valid ),
        .commit_i       ( commit_i       ),
        .flu_ready_i    ( flu_ready_i    ),
        .lsu_ready_i    ( lsu_ready_i    ),
        .mult_pending_i ( mult_pending   ),
        .fwd_rs1_o      ( fwd_rs1        ),
        .fwd_rs2_o      ( fwd_rs2        ),
        .issue_ack_o    ( issue_ack      )
    );

    int_regfile int_regfile_i (
        .clk_i        ( clk_i             ),
        .rst_uarch_ni ( rst_uarch_ni      ),
        .raddr_a_i    ( issue_instr_i.rs1 ),
        .raddr_b_i    ( issue_instr_i.rs2 ),
        .rdata_a_o    ( rdata_a           ),
        .rdata_b_o    ( rdata_b           ),
        .commit_i     ( commit_i          )
    );

    // ----------------------------------------------------------
    // operand build and id to ex register
    // ----------------------------------------------------------
    operand_mux operand_mux_i (
        .issue_instr_i  ( issue_instr_i  ),
        .rdata_a_i      ( rdata_a        ),
        .rdata_b_i      ( rdata_b        ),
        .sb_rs1_value_i ( sb_rs1_i.value ),
        .sb_rs2_value_i ( sb_rs2_i.value ),
        .fwd_rs1_i      ( fwd_rs1        ),
        .fwd_rs2_i      ( fwd_rs2        ),
        .fu_data_next_o ( fu_data_next   )
    );

    dispatch_reg dispatch_reg_i (
        .clk_i          ( clk_i         ),
        .rst_uarch_ni   ( rst_uarch_ni  ),
        .flush_i        ( flush_i       ),
        .fu_data_next_i ( fu_data_next  ),
        .issue_valid_i  ( issue_valid_i ),
        .issue_ack_i    ( issue_ack     ),
        .fu_data_o      ( fu_data_o     ),
        .fu_valid_o     ( fu_valid_o    ),
        .mult_pending_o ( mult_pending  )
    );

endmodule

// File: tests/tb_issue_read_operands.sv
`timescale 1ns/1ps

module tb_issue_read_operands import isa_pkg::*, issue_pkg::*; ();

    localparam int    CLK_PERIOD   = 100;
    localparam int    RESET_CYCLES = 16;
    localparam int    DRIVE_DELAY  = 5;
    // hex columns after the test number
    localparam int    NR_FIELDS    = 26;
    localparam string VEC_FILE     = "tests/issue_tests.txt";

    // expected response of one vector line
    typedef struct packed {
        logic      ack;
        fu_data_t  data;
        fu_valid_t valid;
    } expect_t;

    logic                               clk_i;
    logic                               rst_uarch_ni;
    logic                               flush_i;
    issue_instr_t                       issue_instr_i;
    logic                               issue_valid_i;
    logic                               issue_ack_o;
    logic [REG_ADDR_BITS-1:0]           rs1_o;
    logic [REG_ADDR_BITS-1:0]           rs2_o;
    sb_operand_t                        sb_rs1_i;
    sb_operand_t                        sb_rs2_i;
    clobber_vec_t                       clobber_i;
    commit_port_t [NR_COMMIT_PORTS-1:0] commit_i;
    logic                               flu_ready_i;
    logic                               lsu_ready_i;
    fu_data_t                           fu_data_o;
    fu_valid_t                          fu_valid_o;

    logic [XLEN-1:0] field [NR_FIELDS];
    expect_t         want_now;
    int              n_vec    = 0;
    int              n_tests  = 0;
    int              n_failed = 0;
    int              n_err    = 0;
    int              test_err = 0;

    issue_read_operands issue_read_operands_i (.*);

    initial clk_i = 1'b0;
    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ------------------------------------------------------------
    // vector file access
    // ------------------------------------------------------------
    // comment and blank lines fail the scan and are skipped
    task automatic read_vector(input int fd, output logic found, output int tnum);
        string line;
        int    code;
        found = 1'b0;
        tnum  = 0;
        while (!found && !$feof(fd)) begin
            if ($fgets(line, fd) != 0) begin
                code = $sscanf(line,
                    "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    tnum, field[0], field[1], field[2], field[3], field[4], field[5],
                    field[6], field[7], field[8], field[9], field[10], field[11], field[12],
                    field[13], field[14], field[15], field[16], field[17], field[18],
                    field[19], field[20], field[21], field[22], field[23], field[24],
                    field[25]);
                found = (code == NR_FIELDS + 1);
            end
        end
    endtask

    // drive one vector and note what it should produce
    task automatic apply_vector();
        for (int r = 0; r < NR_REGS; r++) begin
            clobber_i[r] = FU_NONE;
        end
        clobber_i[field[4][REG_ADDR_BITS-1:0]] = fu_e'(field[5][2:0]);
        for (int p = 0; p < 2; p++) begin
            commit_i[p].we    = (field[2*p] != '0);
            commit_i[p].waddr = field[2*p][REG_ADDR_BITS-1:0];
            commit_i[p].wdata = field[2*p+1];
        end
        sb_rs1_i.valid         = field[6][0];
        sb_rs1_i.value         = field[7];
        flu_ready_i            = field[8][0];
        lsu_ready_i            = field[9][0];
        flush_i                = field[10][0];
        issue_valid_i          = field[11][0];
        issue_instr_i.pc       = field[12][VLEN-1:0];
        issue_instr_i.rs1      = field[13][REG_ADDR_BITS-1:0];
        issue_instr_i.rs2      = field[14][REG_ADDR_BITS-1:0];
        issue_instr_i.rd       = field[15][REG_ADDR_BITS-1:0];
        issue_instr_i.imm      = field[16];
        issue_instr_i.fu       = fu_e'(field[17][2:0]);
        issue_instr_i.op       = op_e'(field[18][3:0]);
        // tag is opaque to the stage, any value will do
        issue_instr_i.trans_id = TRANS_ID_BITS'($urandom);
        issue_instr_i.use_pc   = field[19][0];
        issue_instr_i.use_imm  = field[20][0];
        issue_instr_i.use_zimm = field[21][0];
        want_now.ack            = field[22][0];
        want_now.data.operand_a = field[23];
        want_now.data.operand_b = field[24];
        want_now.data.imm       = field[16];
        want_now.data.fu        = issue_instr_i.fu;
        want_now.data.op        = issue_instr_i.op;
        want_now.data.trans_id  = issue_instr_i.trans_id;
        want_now.valid          = field[25][4:0];
    endtask

    // ------------------------------------------------------------
    // checks and report
    // ------------------------------------------------------------
    task automatic check_value(input int tnum, input string name,
                               input logic [XLEN-1:0] got, input logic [XLEN-1:0] want);
        assert (got === want) else begin
            $display("[ERROR] test %0d %s: got %h expected %h", tnum, name, got, want);
            test_err++;
        end
    endtask

    // registered outputs, one cycle after the vector was driven
    task automatic check_outputs(input int tnum, input expect_t want);
        check_value(tnum, "fu_valid_o", XLEN'(fu_valid_o), XLEN'(want.valid));
        // bundle only carries meaning for an accepted instruction
        if (want.ack) begin
            check_value(tnum, "fu_data_o.operand_a", fu_data_o.operand_a, want.data.operand_a);
            check_value(tnum, "fu_data_o.operand_b", fu_data_o.operand_b, want.data.operand_b);
            check_value(tnum, "fu_data_o.imm", fu_data_o.imm, want.data.imm);
            check_value(tnum, "fu_data_o.fu", XLEN'(fu_data_o.fu), XLEN'(want.data.fu));
            check_value(tnum, "fu_data_o.op", XLEN'(fu_data_o.op), XLEN'(want.data.op));
            check_value(tnum, "fu_data_o.trans_id", XLEN'(fu_data_o.trans_id),
                        XLEN'(want.data.trans_id));
        end
    endtask

    task automatic report_test(input int tnum);
        if (test_err == 0) begin
            $display("test %0d passed", tnum);
        end else begin
            $display("test %0d failed with %0d errors", tnum, test_err);
            n_failed++;
        end
        n_tests++;
        n_err   += test_err;
        test_err = 0;
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin : main
        int          fd;
        int          tnum;
        int          prev_tnum;
        logic        found;
        logic        have_prev;
        expect_t     prev_want;
        void'($urandom(32'ha77f));
        rst_uarch_ni  = 1'b0;
        flush_i       = 1'b0;
        issue_valid_i = 1'b0;
        issue_instr_i = '0;
        sb_rs1_i      = '0;
        sb_rs2_i      = '0;
        commit_i      = '0;
        flu_ready_i   = 1'b1;
        lsu_ready_i   = 1'b1;
        for (int r = 0; r < NR_REGS; r++) begin
            clobber_i[r] = FU_NONE;
        end
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("vector file %s could not be opened", VEC_FILE);
            $display("Checks failed");
            $finish;
        end else begin
            // first pass only counts lines, the watchdog needs the total
            read_vector(fd, found, tnum);
            while (found) begin
                n_vec++;
                read_vector(fd, found, tnum);
            end
            $fclose(fd);
            fd = $fopen(VEC_FILE, "r");
            repeat (RESET_CYCLES) @(posedge clk_i);
            #DRIVE_DELAY;
            rst_uarch_ni = 1'b1;
            // reset values, no edge seen since release
            check_value(0, "fu_valid_o", XLEN'(fu_valid_o), '0);
            check_value(0, "fu_data_o.fu", XLEN'(fu_data_o.fu), XLEN'(FU_NONE));
            check_value(0, "fu_data_o.op", XLEN'(fu_data_o.op), XLEN'(OP_ADD));
            report_test(0);
            have_prev = 1'b0;
            prev_tnum = 0;
            read_vector(fd, found, tnum);
            while (found) begin
                @(posedge clk_i);
                #DRIVE_DELAY;
                if (have_prev) begin
                    check_outputs(prev_tnum, prev_want);
                    if (tnum != prev_tnum) begin
                        report_test(prev_tnum);
                    end
                end
                apply_vector();
                // ack is combinational, sample just before the edge
                #(CLK_PERIOD - 2 * DRIVE_DELAY);
                check_value(tnum, "issue_ack_o", XLEN'(issue_ack_o), XLEN'(want_now.ack));
                // scoreboard lookup indices follow the source fields
                check_value(tnum, "rs1_o", XLEN'(rs1_o), XLEN'(field[13][REG_ADDR_BITS-1:0]));
                check_value(tnum, "rs2_o", XLEN'(rs2_o), XLEN'(field[14][REG_ADDR_BITS-1:0]));
                prev_want = want_now;
                prev_tnum = tnum;
                have_prev = 1'b1;
                read_vector(fd, found, tnum);
            end
            @(posedge clk_i);
            #DRIVE_DELAY;
            if (have_prev) begin
                check_outputs(prev_tnum, prev_want);
                report_test(prev_tnum);
            end
            $fclose(fd);
            $display("%0d tests, %0d failed, %0d errors", n_tests, n_failed, n_err);
            if ((n_err == 0) && (n_vec > 0)) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

    // four cycles per vector plus reset is far beyond a healthy run
    initial begin : watchdog
        wait (n_vec > 0);
        #((n_vec * 4 + RESET_CYCLES) * CLK_PERIOD);
        $display("timeout, run did not finish within %0d cycles", n_vec * 4 + RESET_CYCLES);
        $display("Checks failed");
        $finish;
    end

endmodule

// File: verilog.f
verilog/isa_pkg.sv
verilog/issue_pkg.sv
verilog/int_regfile.sv
verilog/operand_hazard.sv
verilog/operand_mux.sv
verilog/dispatch_reg.sv
verilog/issue_read_operands.sv
tests/tb_issue_read_operands.sv

// File: run_sim.sh
#!/bin/sh
# build the issue stage testbench with verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_issue_read_operands -f verilog.f \
    > build.log 2>&1 \
    && ./obj_dir/Vtb_issue_read_operands > sim.log 2>&1 \
    || echo "build or simulation aborted, Checks failed" >> sim.log
cat sim.log
grep -q "Checks failed" sim.log && echo "simulation FAILED, see sim.log" && exit 1
echo "simulation passed"
exit 0

// File: tests/issue_tests.txt
# test c0_addr c0_data c1_addr c1_data clobber_reg clobber_fu sb1_valid sb1_value flu lsu flush
# valid pc rs1 rs2 rd imm fu op use_pc use_imm use_zimm, expected ack op_a op_b fu_valid
# all hex except test, commit addr 0 means no write, fu_valid bits are alu branch lsu mult csr
# committed values reach the operands
1 1 1111 2 2222 0 0 0 0 1 1 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 00
1 3 33 0 0 0 0 0 0 1 1 0 1 0 1 2 4 0 1 0 0 0 0 1 1111 2222 10
1 7 aaaa 7 bbbb 0 0 0 0 1 1 0 1 0 0 3 6 0 1 0 0 0 0 1 0 33 10
1 0 0 0 0 0 0 0 0 1 1 0 1 0 7 0 8 0 1 0 0 0 0 1 bbbb 0 10
# forwarding and stalls
2 0 0 0 0 1 1 1 f00d 1 1 0 1 0 1 2 9 0 1 0 0 0 0 1 f00d 2222 10
2 0 0 0 0 1 1 0 0 1 1 0 1 0 1 2 9 0 1 0 0 0 0 0 0 0 00
2 0 0 0 0 1 6 1 beef 1 1 0 1 0 1 2 9 0 1 0 0 0 0 0 0 0 00
2 0 0 0 0 1 6 1 beef 1 1 0 1 0 1 2 0 0 6 9 0 0 0 1 beef 2222 01
# operand substitution
3 0 0 0 0 0 0 0 0 1 1 0 1 4000000010 1 2 a 0 1 0 1 0 0 1 ffffffc000000010 2222 10
3 0 0 0 0 1d 1 0 0 1 1 0 1 0 1d 0 0 0 6 8 0 0 1 1 1d 0 01
3 0 0 0 0 0 0 0 0 1 1 0 1 0 1 2 a 7ff 1 0 0 1 0 1 1111 7ff 10
3 0 0 0 0 0 0 0 0 1 1 0 1 0 1 2 0 10 4 4 0 1 0 1 1111 2222 04
# write-after-write and back-pressure
4 0 0 0 0 4 3 0 0 1 1 0 1 0 1 2 4 0 1 0 0 0 0 0 0 0 00
4 4 4444 0 0 4 3 0 0 1 1 0 1 0 1 2 4 0 1 0 0 0 0 1 1111 2222 10
4 0 0 0 0 0 0 0 0 0 1 0 1 0 1 2 b 0 1 0 0 0 0 0 0 0 00
4 0 0 0 0 0 0 0 0 1 0 0 1 0 1 0 c 8 3 3 0 1 0 0 0 0 00
4 0 0 0 0 0 0 0 0 1 0 0 1 0 1 2 b 0 1 0 0 0 0 1 1111 2222 10
# unit pulses and flush
5 0 0 0 0 0 0 0 0 1 1 0 1 0 1 0 c 8 3 3 0 1 0 1 1111 8 04
5 0 0 0 0 0 0 0 0 1 1 0 1 0 1 2 0 20 2 5 0 1 0 1 1111 2222 08
5 0 0 0 0 0 0 0 0 1 1 1 1 0 1 2 b 0 1 0 0 0 0 1 1111 2222 00
# multiply follow rule
6 0 0 0 0 0 0 0 0 1 1 0 1 0 1 2 d 0 5 7 0 0 0 1 1111 2222 02
6 0 0 0 0 0 0 0 0 1 1 0 1 0 1 2 b 0 1 0 0 0 0 0 0 0 00
6 0 0 0 0 0 0 0 0 1 1 0 1 0 1 2 d 0 5 7 0 0 0 1 1111 2222 02
6 0 0 0 0 0 0 0 0 1 1 0 1 0 1 2 d 0 5 7 0 0 0 1 1111 2222 02
6 0 0 0 0 0 0 0 0 1 1 0 1 0 1 2 b 0 1 0 0 0 0 0 0 0 00
6 0 0 0 0 0 0 0 0 1 1 0 1 0 1 2 b 0 1 0 0 0 0 1 1111 2222 10
# no unit needed, accepted with both units busy
7 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 1 0 0 00
